/* src/core_pkg.sv */
package core_pkg;

	// data and address width
	localparam int XLEN = 32;

	// register file geometry
	localparam int REG_COUNT = 32;
	localparam int REG_AW = 5;

	// first fetch address after reset
	localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

	// major opcodes, inst[6:0]
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// the only SYSTEM word this core accepts
	localparam logic [XLEN-1:0] EBREAK_WORD = 32'h0010_0073;

	// funct3 for OP and OP-IMM
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SRL  = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// funct3 for conditional branches
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// funct7, base vs alternate (sub, sra)
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		// lui, result is operand b
		ALU_PASS_B
	} alu_op_e;

	// writeback source
	typedef enum logic [1:0] {
		WB_ALU,
		WB_PC4
	} wb_sel_e;

	typedef enum logic [3:0] {
		BR_NONE,
		BR_JAL,
		BR_JALR,
		BR_BEQ,
		BR_BNE,
		BR_BLT,
		BR_BGE,
		BR_BLTU,
		BR_BGEU
	} br_type_e;

	// instruction formats, msb first
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_type_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_type_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_type_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_type_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_type_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_type_t;

	// one fetched word, six views
	typedef union packed {
		r_type_t r;
		i_type_t i;
		s_type_t s;
		b_type_t b;
		u_type_t u;
		j_type_t j;
	} rv_inst_u;

endpackage

/* src/pc_counter.sv */
module pc_counter (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      redirect_i,
	input  logic [core_pkg::XLEN-1:0] target_i,
	input  logic                      halt_i,
	output logic [core_pkg::XLEN-1:0] pc_o,
	output logic [core_pkg::XLEN-1:0] pc_plus4_o
);

	logic [core_pkg::XLEN-1:0] pc_q;
	logic [core_pkg::XLEN-1:0] pc_next;

	// sequential successor, also the link value for jal/jalr
	assign pc_plus4_o = pc_q + core_pkg::XLEN'(4);

	// halt beats redirect, redirect beats fall-through
	always_comb begin
		if (halt_i) begin
			pc_next = pc_q;
		end else if (redirect_i) begin
			pc_next = target_i;
		end else begin
			pc_next = pc_plus4_o;
		end
	end

	// reset vector held through reset and the first cycle out of it
	always_ff @(posedge clk) begin
		if (!rst) begin
			pc_q <= core_pkg::RESET_PC;
		end else begin
			pc_q <= pc_next;
		end
	end

	assign pc_o = pc_q;

endmodule

/* src/register_file.sv */
module register_file (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        wen_i,
	input  logic [core_pkg::REG_AW-1:0] waddr_i,
	input  logic [core_pkg::XLEN-1:0]   wdata_i,
	input  logic [core_pkg::REG_AW-1:0] raddr1_i,
	input  logic [core_pkg::REG_AW-1:0] raddr2_i,
	output logic [core_pkg::XLEN-1:0]   rdata1_o,
	output logic [core_pkg::XLEN-1:0]   rdata2_o
);

	logic [core_pkg::XLEN-1:0] regs [core_pkg::REG_COUNT];
	logic                      wr_hit;

	// x0 is never written
	assign wr_hit = wen_i && (waddr_i != '0);

	// all registers cleared in reset
	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int idx = 0; idx < core_pkg::REG_COUNT; idx++) begin
				regs[idx] <= '0;
			end
		end else if (wr_hit) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// async reads with no bypass
	// a write in this cycle shows up on the next one
	always_comb begin
		if (raddr1_i == '0) begin
			rdata1_o = '0;
		end else begin
			rdata1_o = regs[raddr1_i];
		end
		if (raddr2_i == '0) begin
			rdata2_o = '0;
		end else begin
			rdata2_o = regs[raddr2_i];
		end
	end

endmodule

/* src/inst_decoder.sv */
module inst_decoder (
	input  logic                        rst,
	input  core_pkg::rv_inst_u          inst_i,
	input  logic [core_pkg::XLEN-1:0]   pc_i,
	input  logic [core_pkg::XLEN-1:0]   rs1_data_i,
	input  logic [core_pkg::XLEN-1:0]   rs2_data_i,
	output logic [core_pkg::REG_AW-1:0] rs1_addr_o,
	output logic [core_pkg::REG_AW-1:0] rs2_addr_o,
	output core_pkg::alu_op_e           alu_op_o,
	output logic [core_pkg::XLEN-1:0]   operand_a_o,
	output logic [core_pkg::XLEN-1:0]   operand_b_o,
	output logic [core_pkg::XLEN-1:0]   rs2_val_o,
	output core_pkg::wb_sel_e           wb_sel_o,
	output core_pkg::br_type_e          br_type_o,
	output logic [core_pkg::XLEN-1:0]   br_target_o,
	output logic                        wen_o,
	output logic [core_pkg::REG_AW-1:0] rd_o,
	output logic                        invalid_o,
	output logic                        ebreak_o
);

	logic [6:0]                opcode;
	logic [2:0]                funct3;
	logic [6:0]                funct7;
	logic [core_pkg::XLEN-1:0] imm_i;
	logic [core_pkg::XLEN-1:0] imm_b;
	logic [core_pkg::XLEN-1:0] imm_u;
	logic [core_pkg::XLEN-1:0] imm_j;
	logic [core_pkg::XLEN-1:0] imm;
	logic [core_pkg::XLEN-1:0] target_base;
	logic [core_pkg::XLEN-1:0] target_sum;
	logic                      legal;
	logic                      writes_rd;
	logic                      use_pc_a;
	logic                      use_imm_b;
	logic                      is_ebreak;
	core_pkg::br_type_e        br_type;

	// register and funct fields sit in the same place for every format
	assign opcode     = inst_i.r.opcode;
	assign funct3     = inst_i.r.funct3;
	assign funct7     = inst_i.r.funct7;
	assign rs1_addr_o = inst_i.r.rs1;
	assign rs2_addr_o = inst_i.r.rs2;
	assign rd_o       = inst_i.r.rd;

	// immediates through their own views, all sign extended from inst[31]
	assign imm_i = {{20{inst_i.i.imm_11_0[11]}}, inst_i.i.imm_11_0};
	assign imm_b = {{19{inst_i.b.imm_12}}, inst_i.b.imm_12, inst_i.b.imm_11,
	                inst_i.b.imm_10_5, inst_i.b.imm_4_1, 1'b0};
	assign imm_u = {inst_i.u.imm_31_12, 12'b0};
	assign imm_j = {{11{inst_i.j.imm_20}}, inst_i.j.imm_20, inst_i.j.imm_19_12,
	                inst_i.j.imm_11, inst_i.j.imm_10_1, 1'b0};

	// exact match, ecall and csr words are rejected
	assign is_ebreak = (inst_i == core_pkg::EBREAK_WORD);

	always_comb begin
		legal     = 1'b0;
		writes_rd = 1'b0;
		use_pc_a  = 1'b0;
		use_imm_b = 1'b0;
		imm       = imm_i;
		alu_op_o  = core_pkg::ALU_ADD;
		wb_sel_o  = core_pkg::WB_ALU;
		br_type   = core_pkg::BR_NONE;
		case (opcode)
			core_pkg::OPC_LUI: begin
				legal     = 1'b1;
				writes_rd = 1'b1;
				use_imm_b = 1'b1;
				imm       = imm_u;
				alu_op_o  = core_pkg::ALU_PASS_B;
			end
			core_pkg::OPC_AUIPC: begin
				legal     = 1'b1;
				writes_rd = 1'b1;
				use_pc_a  = 1'b1;
				use_imm_b = 1'b1;
				imm       = imm_u;
			end
			core_pkg::OPC_JAL: begin
				legal     = 1'b1;
				writes_rd = 1'b1;
				imm       = imm_j;
				wb_sel_o  = core_pkg::WB_PC4;
				br_type   = core_pkg::BR_JAL;
			end
			core_pkg::OPC_JALR: begin
				// only funct3 000 is defined
				legal     = (funct3 == 3'b000);
				writes_rd = 1'b1;
				wb_sel_o  = core_pkg::WB_PC4;
				br_type   = core_pkg::BR_JALR;
			end
			core_pkg::OPC_BRANCH: begin
				imm   = imm_b;
				legal = 1'b1;
				case (funct3)
					core_pkg::F3_BEQ:  br_type = core_pkg::BR_BEQ;
					core_pkg::F3_BNE:  br_type = core_pkg::BR_BNE;
					core_pkg::F3_BLT:  br_type = core_pkg::BR_BLT;
					core_pkg::F3_BGE:  br_type = core_pkg::BR_BGE;
					core_pkg::F3_BLTU: br_type = core_pkg::BR_BLTU;
					core_pkg::F3_BGEU: br_type = core_pkg::BR_BGEU;
					// 010 and 011 are reserved
					default:           legal = 1'b0;
				endcase
			end
			core_pkg::OPC_OP_IMM: begin
				legal     = 1'b1;
				writes_rd = 1'b1;
				use_imm_b = 1'b1;
				case (funct3)
					core_pkg::F3_ADD:  alu_op_o = core_pkg::ALU_ADD;
					core_pkg::F3_SLT:  alu_op_o = core_pkg::ALU_SLT;
					core_pkg::F3_SLTU: alu_op_o = core_pkg::ALU_SLTU;
					core_pkg::F3_XOR:  alu_op_o = core_pkg::ALU_XOR;
					core_pkg::F3_OR:   alu_op_o = core_pkg::ALU_OR;
					core_pkg::F3_AND:  alu_op_o = core_pkg::ALU_AND;
					core_pkg::F3_SLL: begin
						alu_op_o = core_pkg::ALU_SLL;
						legal    = (funct7 == core_pkg::F7_BASE);
					end
					default: begin
						// srli / srai, upper imm bits pick the shift
						alu_op_o = (funct7 == core_pkg::F7_ALT) ? core_pkg::ALU_SRA
						                                        : core_pkg::ALU_SRL;
						legal    = (funct7 == core_pkg::F7_BASE) ||
						           (funct7 == core_pkg::F7_ALT);
					end
				endcase
			end
			core_pkg::OPC_OP: begin
				writes_rd = 1'b1;
				legal     = (funct7 == core_pkg::F7_BASE);
				case (funct3)
					core_pkg::F3_ADD: begin
						// add or sub
						alu_op_o = (funct7 == core_pkg::F7_ALT) ? core_pkg::ALU_SUB
						                                        : core_pkg::ALU_ADD;
						legal    = legal || (funct7 == core_pkg::F7_ALT);
					end
					core_pkg::F3_SRL: begin
						alu_op_o = (funct7 == core_pkg::F7_ALT) ? core_pkg::ALU_SRA
						                                        : core_pkg::ALU_SRL;
						legal    = legal || (funct7 == core_pkg::F7_ALT);
					end
					core_pkg::F3_SLL:  alu_op_o = core_pkg::ALU_SLL;
					core_pkg::F3_SLT:  alu_op_o = core_pkg::ALU_SLT;
					core_pkg::F3_SLTU: alu_op_o = core_pkg::ALU_SLTU;
					core_pkg::F3_XOR:  alu_op_o = core_pkg::ALU_XOR;
					core_pkg::F3_OR:   alu_op_o = core_pkg::ALU_OR;
					default:           alu_op_o = core_pkg::ALU_AND;
				endcase
			end
			core_pkg::OPC_LOAD,
			core_pkg::OPC_STORE: begin
				// no data memory here, flagged like any unknown word
				legal = 1'b0;
			end
			core_pkg::OPC_SYSTEM: begin
				legal = is_ebreak;
			end
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	// operand muxes
	assign operand_a_o = use_pc_a ? pc_i : rs1_data_i;
	assign operand_b_o = use_imm_b ? imm : rs2_data_i;
	// rs2 for the branch comparator
	assign rs2_val_o = rs2_data_i;

	// jalr adds to rs1, everything else is pc relative
	assign target_base = (br_type == core_pkg::BR_JALR) ? rs1_data_i : pc_i;
	assign target_sum  = target_base + imm;
	assign br_target_o = {target_sum[core_pkg::XLEN-1:1],
	                      target_sum[0] & (br_type != core_pkg::BR_JALR)};

	// illegal words must not redirect either
	assign br_type_o = legal ? br_type : core_pkg::BR_NONE;

	// write enable held low in reset, on bad words and on ebreak
	assign wen_o     = rst && legal && writes_rd && !is_ebreak;
	assign invalid_o = !legal;
	assign ebreak_o  = is_ebreak;

endmodule

/* src/execute_unit.sv */
module execute_unit (
	input  core_pkg::alu_op_e           alu_op_i,
	input  logic [core_pkg::XLEN-1:0]   operand_a_i,
	input  logic [core_pkg::XLEN-1:0]   operand_b_i,
	input  logic [core_pkg::XLEN-1:0]   rs1_val_i,
	input  logic [core_pkg::XLEN-1:0]   rs2_val_i,
	input  logic [core_pkg::XLEN-1:0]   pc_plus4_i,
	input  core_pkg::wb_sel_e           wb_sel_i,
	input  core_pkg::br_type_e          br_type_i,
	input  logic                        wen_i,
	input  logic [core_pkg::REG_AW-1:0] rd_i,
	output logic                        redirect_o,
	output logic                        wen_o,
	output logic [core_pkg::REG_AW-1:0] waddr_o,
	output logic [core_pkg::XLEN-1:0]   wdata_o
);

	logic [4:0]                shamt;
	logic [core_pkg::XLEN-1:0] alu_result;
	logic                      alu_lt_s;
	logic                      alu_lt_u;
	logic                      br_eq;
	logic                      br_lt_s;
	logic                      br_lt_u;

	// rv32 shifts use only the low five bits
	assign shamt = operand_b_i[4:0];

	assign alu_lt_s = $signed(operand_a_i) < $signed(operand_b_i);
	assign alu_lt_u = operand_a_i < operand_b_i;

	always_comb begin
		case (alu_op_i)
			core_pkg::ALU_ADD:    alu_result = operand_a_i + operand_b_i;
			core_pkg::ALU_SUB:    alu_result = operand_a_i - operand_b_i;
			core_pkg::ALU_SLL:    alu_result = operand_a_i << shamt;
			core_pkg::ALU_SLT:    alu_result = {{(core_pkg::XLEN-1){1'b0}}, alu_lt_s};
			core_pkg::ALU_SLTU:   alu_result = {{(core_pkg::XLEN-1){1'b0}}, alu_lt_u};
			core_pkg::ALU_XOR:    alu_result = operand_a_i ^ operand_b_i;
			core_pkg::ALU_SRL:    alu_result = operand_a_i >> shamt;
			// arithmetic shift keeps the sign
			core_pkg::ALU_SRA:    alu_result = $signed(operand_a_i) >>> shamt;
			core_pkg::ALU_OR:     alu_result = operand_a_i | operand_b_i;
			core_pkg::ALU_AND:    alu_result = operand_a_i & operand_b_i;
			core_pkg::ALU_PASS_B: alu_result = operand_b_i;
			default:              alu_result = '0;
		endcase
	end

	// branch compare on raw register values
	assign br_eq   = rs1_val_i == rs2_val_i;
	assign br_lt_s = $signed(rs1_val_i) < $signed(rs2_val_i);
	assign br_lt_u = rs1_val_i < rs2_val_i;

	always_comb begin
		case (br_type_i)
			core_pkg::BR_JAL,
			core_pkg::BR_JALR: redirect_o = 1'b1;
			core_pkg::BR_BEQ:  redirect_o = br_eq;
			core_pkg::BR_BNE:  redirect_o = !br_eq;
			core_pkg::BR_BLT:  redirect_o = br_lt_s;
			core_pkg::BR_BGE:  redirect_o = !br_lt_s;
			core_pkg::BR_BLTU: redirect_o = br_lt_u;
			core_pkg::BR_BGEU: redirect_o = !br_lt_u;
			default:           redirect_o = 1'b0;
		endcase
	end

	// writeback trio, link value for jumps
	assign wen_o   = wen_i;
	assign waddr_o = rd_i;
	assign wdata_o = (wb_sel_i == core_pkg::WB_PC4) ? pc_plus4_i : alu_result;

endmodule

/* src/core_top.sv */
module core_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [core_pkg::XLEN-1:0]   inst_i,
	output logic [core_pkg::XLEN-1:0]   pc_o,
	output logic                        wb_wen_o,
	output logic [core_pkg::REG_AW-1:0] wb_waddr_o,
	output logic [core_pkg::XLEN-1:0]   wb_wdata_o,
	output logic                        invalid_o,
	output logic                        ebreak_o
);

	// register file read side
	logic [core_pkg::REG_AW-1:0] rs1_addr;
	logic [core_pkg::REG_AW-1:0] rs2_addr;
	logic [core_pkg::XLEN-1:0]   rs1_data;
	logic [core_pkg::XLEN-1:0]   rs2_data;

	// decoder to execute
	core_pkg::alu_op_e           alu_op;
	logic [core_pkg::XLEN-1:0]   operand_a;
	logic [core_pkg::XLEN-1:0]   operand_b;
	logic [core_pkg::XLEN-1:0]   rs2_val;
	core_pkg::wb_sel_e           wb_sel;
	core_pkg::br_type_e          br_type;
	logic                        dec_wen;
	logic [core_pkg::REG_AW-1:0] dec_rd;

	// next pc control
	logic [core_pkg::XLEN-1:0]   br_target;
	logic [core_pkg::XLEN-1:0]   pc_plus4;
	logic                        redirect;

	// ebreak freezes the pc
	pc_counter u_pc_counter (
		.clk        (clk),
		.rst        (rst),
		.redirect_i (redirect),
		.target_i   (br_target),
		.halt_i     (ebreak_o),
		.pc_o       (pc_o),
		.pc_plus4_o (pc_plus4)
	);

	// write port fed straight from the writeback outputs
	register_file u_register_file (
		.clk      (clk),
		.rst      (rst),
		.wen_i    (wb_wen_o),
		.waddr_i  (wb_waddr_o),
		.wdata_i  (wb_wdata_o),
		.raddr1_i (rs1_addr),
		.raddr2_i (rs2_addr),
		.rdata1_o (rs1_data),
		.rdata2_o (rs2_data)
	);

	inst_decoder u_inst_decoder (
		.rst         (rst),
		.inst_i      (inst_i),
		.pc_i        (pc_o),
		.rs1_data_i  (rs1_data),
		.rs2_data_i  (rs2_data),
		.rs1_addr_o  (rs1_addr),
		.rs2_addr_o  (rs2_addr),
		.alu_op_o    (alu_op),
		.operand_a_o (operand_a),
		.operand_b_o (operand_b),
		.rs2_val_o   (rs2_val),
		.wb_sel_o    (wb_sel),
		.br_type_o   (br_type),
		.br_target_o (br_target),
		.wen_o       (dec_wen),
		.rd_o        (dec_rd),
		.invalid_o   (invalid_o),
		.ebreak_o    (ebreak_o)
	);

	// comparator gets rs1 straight from the register file
	execute_unit u_execute_unit (
		.alu_op_i    (alu_op),
		.operand_a_i (operand_a),
		.operand_b_i (operand_b),
		.rs1_val_i   (rs1_data),
		.rs2_val_i   (rs2_val),
		.pc_plus4_i  (pc_plus4),
		.wb_sel_i    (wb_sel),
		.br_type_i   (br_type),
		.wen_i       (dec_wen),
		.rd_i        (dec_rd),
		.redirect_o  (redirect),
		.wen_o       (wb_wen_o),
		.waddr_o     (wb_waddr_o),
		.wdata_o     (wb_wdata_o)
	);

endmodule

/* sim/core_asserts.sv */
module core_asserts (
	input logic                      clk,
	input logic                      rst,
	input logic [core_pkg::XLEN-1:0] pc_i,
	input logic                      wb_wen_i,
	input logic                      invalid_i,
	input logic                      ebreak_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// fetch address always on a word boundary
	pc_aligned: assert property (@(posedge clk) disable iff (!rst) pc_i[1:0] == 2'b00)
		else $error("pc_o is not word aligned");

	// illegal words never reach the register file
	no_write_on_invalid: assert property (@(posedge clk) disable iff (!rst)
		invalid_i |-> !wb_wen_i)
		else $error("wb_wen_o high on an invalid word");

	// ebreak freezes the pc for the next cycle
	halt_holds_pc: assert property (@(posedge clk) disable iff (!rst)
		ebreak_i |=> $stable(pc_i))
		else $error("pc_o moved after ebreak");

	// first commit after reset comes from the reset vector
	reset_vector: assert property (@(posedge clk) $rose(rst) |-> pc_i == core_pkg::RESET_PC)
		else $error("pc_o is not the reset vector after reset release");

endmodule

bind core_top core_asserts u_core_asserts (
	.clk       (clk),
	.rst       (rst),
	.pc_i      (pc_o),
	.wb_wen_i  (wb_wen_o),
	.invalid_i (invalid_o),
	.ebreak_i  (ebreak_o)
);

/* sim/core_tb.sv */
module core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 10;
	localparam int RNG_SEED     = 34;
	// cycles any single wait may take
	localparam int WAIT_LIMIT   = 20;
	// pc, word, wen, rd, wdata, invalid
	localparam int REC_WORDS    = 6;
	localparam int MAX_RECS     = 64;
	localparam int PAT_DEPTH    = 1 + REC_WORDS * MAX_RECS;

	// starts low so no falling edge appears at time zero
	logic                        clk = 1'b0;
	logic                        rst;
	logic [core_pkg::XLEN-1:0]   inst;
	logic [core_pkg::XLEN-1:0]   pc;
	logic                        wb_wen;
	logic [core_pkg::REG_AW-1:0] wb_waddr;
	logic [core_pkg::XLEN-1:0]   wb_wdata;
	logic                        invalid;
	logic                        ebreak;

	// raw pattern words and the fetch model built from them
	logic [core_pkg::XLEN-1:0] pat [PAT_DEPTH];
	logic [core_pkg::XLEN-1:0] imem [logic [core_pkg::XLEN-1:0]];
	int                        rec_count;
	int                        err_count;
	int                        check_count;
	logic                      run_ok;

	core_top DUT (
		.clk        (clk),
		.rst        (rst),
		.inst_i     (inst),
		.pc_o       (pc),
		.wb_wen_o   (wb_wen),
		.wb_waddr_o (wb_waddr),
		.wb_wdata_o (wb_wdata),
		.invalid_o  (invalid),
		.ebreak_o   (ebreak)
	);

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// unmapped addresses return zero and decode as illegal
	function automatic logic [core_pkg::XLEN-1:0] fetch(input logic [core_pkg::XLEN-1:0] addr);
		if (imem.exists(addr)) begin
			return imem[addr];
		end else begin
			return '0;
		end
	endfunction

	task automatic check_word(input string name, input logic [core_pkg::XLEN-1:0] got,
	                          input logic [core_pkg::XLEN-1:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input logic [core_pkg::REG_AW-1:0] got,
	                          input logic [core_pkg::REG_AW-1:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// word 0 holds the record count and each record carries its program word
	task automatic load_patterns;
		int base;
		$readmemh("sim/core_patterns.txt", pat);
		rec_count = int'(pat[0]);
		if (rec_count < 1 || rec_count > MAX_RECS) begin
			$display("pattern file has a bad record count of %0d", rec_count);
			run_ok = 1'b0;
			rec_count = 0;
		end
		for (int k = 0; k < rec_count; k++) begin
			base = 1 + k * REC_WORDS;
			imem[pat[base]] = pat[base + 1];
		end
	endtask

	// random words on the bus during reset must not raise wen
	task automatic apply_reset;
		rst = 1'b0;
		repeat (RESET_CYCLES - 1) begin
			@(negedge clk);
			inst = $urandom;
			#1;
			check_word("pc_o", pc, core_pkg::RESET_PC);
			check_bit("wb_wen_o", wb_wen, 1'b0);
		end
		@(negedge clk);
		rst  = 1'b1;
		inst = fetch(pc);
	endtask

	task automatic wait_first_pc(output logic ok);
		int waited;
		waited = 0;
		while (pc !== core_pkg::RESET_PC && waited < WAIT_LIMIT) begin
			@(negedge clk);
			inst = fetch(pc);
			#1;
			waited++;
		end
		ok = (pc === core_pkg::RESET_PC);
		if (!ok) begin
			$display("timeout: pc_o never showed the reset vector after reset release");
		end
	endtask

	// one record per cycle
	// rd and wdata only compared when wen is set
	task automatic play_trace;
		int base;
		for (int k = 0; k < rec_count; k++) begin
			base = 1 + k * REC_WORDS;
			if (k != 0) begin
				@(negedge clk);
				inst = fetch(pc);
			end
			#1;
			check_word("pc_o", pc, pat[base]);
			check_bit("wb_wen_o", wb_wen, pat[base + 2][0]);
			check_bit("invalid_o", invalid, pat[base + 5][0]);
			if (pat[base + 2][0]) begin
				check_addr("wb_waddr_o", wb_waddr, pat[base + 3][core_pkg::REG_AW-1:0]);
				check_word("wb_wdata_o", wb_wdata, pat[base + 4]);
			end
		end
	endtask

	task automatic wait_ebreak(output logic ok);
		int waited;
		waited = 0;
		while (ebreak !== 1'b1 && waited < WAIT_LIMIT) begin
			@(negedge clk);
			inst = fetch(pc);
			#1;
			waited++;
		end
		ok = (ebreak === 1'b1);
		if (!ok) begin
			$display("timeout: ebreak_o did not rise within %0d cycles", WAIT_LIMIT);
		end
	endtask

	// core parked on ebreak with pc frozen and nothing written
	task automatic check_halt;
		logic [core_pkg::XLEN-1:0] halt_pc;
		halt_pc = pc;
		repeat (2) begin
			@(negedge clk);
			inst = fetch(pc);
			#1;
			check_word("pc_o", pc, halt_pc);
			check_bit("ebreak_o", ebreak, 1'b1);
			check_bit("wb_wen_o", wb_wen, 1'b0);
		end
	endtask

	initial begin
		void'($urandom(RNG_SEED));
		rst         = 1'b0;
		inst        = '0;
		err_count   = 0;
		check_count = 0;
		run_ok      = 1'b1;
		load_patterns();
		apply_reset();
		if (run_ok) wait_first_pc(run_ok);
		if (run_ok) play_trace();
		if (run_ok) wait_ebreak(run_ok);
		if (run_ok) check_halt();
		$display("checks %0d, errors %0d", check_count, err_count);
		if (run_ok && err_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* sim/core_patterns.txt */
// first word: record count; then one record per committed cycle, all hex
// pc  word  wen  rd  wdata  invalid   (rd and wdata unused when wen is 0)
0000002a
80000000 00500093 1 01 00000005 0
80000004 ffd00113 1 02 fffffffd 0
80000008 002081b3 1 03 00000002 0
8000000c 40208233 1 04 00000008 0
80000010 001122b3 1 05 00000001 0
80000014 00113333 1 06 00000000 0
80000018 0020c3b3 1 07 fffffff8 0
8000001c 0020e433 1 08 fffffffd 0
80000020 0020f4b3 1 09 00000005 0
80000024 00309533 1 0a 00000014 0
80000028 003155b3 1 0b 3fffffff 0
8000002c 40315633 1 0c ffffffff 0
80000030 fff12693 1 0d 00000001 0
80000034 fff0b713 1 0e 00000001 0
80000038 0ff0c793 1 0f 000000fa 0
8000003c 0300e813 1 10 00000035 0
80000040 0f017893 1 11 000000f0 0
80000044 00409913 1 12 00000050 0
80000048 01c15993 1 13 0000000f 0
8000004c 40115a13 1 14 fffffffe 0
80000050 00708013 1 00 0000000c 0
80000054 00100ab3 1 15 00000005 0
80000058 12345b37 1 16 12345000 0
8000005c 00001b97 1 17 8000105c 0
80000060 00208463 0 00 00000000 0
80000064 00108463 0 00 00000000 0
8000006c 00109463 0 00 00000000 0
80000070 00209463 0 00 00000000 0
80000078 0020c463 0 00 00000000 0
8000007c 00114463 0 00 00000000 0
80000084 00115463 0 00 00000000 0
80000088 0020d463 0 00 00000000 0
80000090 00116463 0 00 00000000 0
80000094 0020e463 0 00 00000000 0
8000009c 0020f463 0 00 00000000 0
800000a0 00117463 0 00 00000000 0
800000a8 00c00c6f 1 18 800000ac 0
800000b4 015c0ce7 1 19 800000b8 0
800000c0 01450d33 1 1a 00000012 0
800000c4 416b8db3 1 1b 6dcbc05c 0
800000c8 00112023 0 00 00000000 1
800000cc 00100073 0 00 00000000 0

/* vlog.f */
src/core_pkg.sv
src/pc_counter.sv
src/register_file.sv
src/inst_decoder.sv
src/execute_unit.sv
src/core_top.sv
sim/core_asserts.sv
sim/core_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module core_tb --Mdir obj_dir -f vlog.f

if ./obj_dir/Vcore_tb > sim.log 2>&1; then
	status=0
else
	status=$?
fi
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation finished: FAIL" sim.log; then
	exit 1
fi
exit 0
